// File: include/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define XLEN     32
`define RESET_PC 32'h0000_0000
`define NUM_REGS 32

`endif

// File: logic/alu.sv
module alu (
	input  rv_pkg::instr_t instr,
	input  rv_pkg::data_t  a_in,
	input  rv_pkg::data_t  b_in,
	output rv_pkg::data_t  c_out,
	output logic           rd_wr
);
	import rv_pkg::*;

	opcode_t     opcode;
	funct3_t     funct3;
	shift_type_t shift_type;
	logic        sub_func;
	logic [4:0]  shift_amt;
	data_t       op_b;
	data_t       adder_b;
	data_t       and_result;
	data_t       or_result;
	data_t       xor_result;
	data_t       set_result;
	data_t       shift_result;
	data_t       add_sub_result;

	always_comb begin
		opcode     = instr.r_fmt.opcode;
		funct3     = instr.r_fmt.funct3;
		shift_type = shift_type_t'(instr.r_fmt.funct7[5]); // bit 30
		sub_func   = (opcode == R) && instr.r_fmt.funct7[5];
		op_b       = (opcode == I) ? get_imm(instr) : b_in;
		shift_amt  = (opcode == I) ? instr.r_fmt.rs2 : b_in[4:0]; // shamt sits in the rs2 field
	end

	always_comb begin
		and_result = a_in & op_b;
		or_result  = a_in | op_b;
		xor_result = a_in ^ op_b;
	end

	// b_in carries the immediate for slti/sltiu
	always_comb begin
		set_result = NULL;
		if ((funct3 == SLT && $signed(a_in) < $signed(b_in)) ||
			(funct3 == SLTU && a_in < b_in)) begin
			set_result = data_t'(1);
		end
	end

	always_comb begin
		shift_result = NULL;
		if (funct3 == SLL) begin
			shift_result = a_in << shift_amt;
		end else if (funct3 == SRL && shift_type == arithmetic) begin
			shift_result = $signed(a_in) >>> shift_amt;
		end else if (funct3 == SRL) begin
			shift_result = a_in >> shift_amt;
		end
	end

	always_comb begin
		adder_b        = sub_func ? ~op_b : op_b;
		add_sub_result = a_in + adder_b + data_t'(sub_func); // a + ~b + 1 on sub
	end

	always_comb begin
		c_out = NULL;
		rd_wr = 1'b0;
		unique case (opcode)
			R: begin
				rd_wr = 1'b1;
				unique case (funct3)
					ADD:       c_out = add_sub_result;
					SLL, SRL:  c_out = shift_result;
					SLT, SLTU: c_out = set_result;
					XOR:       c_out = xor_result;
					OR:        c_out = or_result;
					AND:       c_out = and_result;
				endcase
			end
			I: begin
				rd_wr = 1'b1;
				unique case (funct3)
					ADDI:        c_out = add_sub_result;
					SLLI, SRLI:  c_out = shift_result; // srai too
					SLTI, SLTIU: c_out = set_result;
					XORI:        c_out = xor_result;
					ORI:         c_out = or_result;
					ANDI:        c_out = and_result;
				endcase
			end
			LUI: begin
				c_out = b_in; // already shifted up
				rd_wr = 1'b1;
			end
			AUIPC, JAL, JALR, LOAD: begin
				c_out = add_sub_result; // pc + imm, link or load address
				rd_wr = 1'b1;
			end
			STORE:   c_out = add_sub_result;
			default: rd_wr = 1'b0; // branches, fence, sys
		endcase
	end
endmodule

// File: logic/core_ctrl.sv
module core_ctrl (
	input  logic           clk,
	input  logic           rst,
	input  rv_pkg::instr_t instr,
	input  logic           instr_valid,
	input  rv_pkg::data_t  pc,
	output logic           fetch_start,
	output logic           pc_load,
	output rv_pkg::data_t  next_pc,
	output logic [4:0]     rs1_addr,
	output logic [4:0]     rs2_addr,
	input  rv_pkg::data_t  rs1_data,
	input  rv_pkg::data_t  rs2_data,
	output rv_pkg::data_t  alu_a,
	output rv_pkg::data_t  alu_b,
	input  rv_pkg::data_t  alu_c,
	input  logic           alu_wr,
	output logic [4:0]     rd_addr,
	output rv_pkg::data_t  rd_data,
	output logic           rd_we,
	output logic           ls_start,
	output rv_pkg::data_t  ls_addr,
	output rv_pkg::data_t  ls_wdata,
	output logic           ls_we,
	input  rv_pkg::data_t  ls_rdata,
	input  logic           ls_done,
	output logic           halted
);
	import rv_pkg::*;

	typedef enum logic [1:0] {S_FETCH, S_EXEC, S_MEM} state_t;

	state_t  state;
	logic    fetch_wait; // fetch issued, word not back yet
	opcode_t opcode;
	logic    is_mem;
	logic    take;
	logic    rs_eq;
	logic    rs_lt;
	data_t   target_base;
	data_t   target_off;
	data_t   target;

	assign opcode   = instr.r_fmt.opcode;
	assign rs1_addr = instr.r_fmt.rs1;
	assign rs2_addr = instr.r_fmt.rs2;
	assign rd_addr  = instr.r_fmt.rd;
	assign is_mem   = (opcode == LOAD) || (opcode == STORE);

	always_comb begin
		alu_a = rs1_data;
		alu_b = rs2_data;
		unique case (opcode)
			JAL, JALR: begin
				alu_a = pc; // link value pc + 4
				alu_b = data_t'(4);
			end
			AUIPC: begin
				alu_a = pc;
				alu_b = get_imm_u(instr);
			end
			LUI:     alu_b = get_imm_u(instr);
			I, LOAD: alu_b = get_imm(instr);
			STORE:   alu_b = get_imm_s(instr);
			default: alu_b = rs2_data;
		endcase
	end

	// branch decision and target adder
	always_comb begin
		rs_eq       = rs1_data == rs2_data;
		rs_lt       = $signed(rs1_data) < $signed(rs2_data);
		take        = 1'b0;
		target_base = pc;
		target_off  = get_imm_b(instr);
		unique case (opcode)
			JAL: begin
				take       = 1'b1;
				target_off = get_imm_j(instr);
			end
			JALR: begin
				take        = 1'b1;
				target_base = rs1_data;
				target_off  = get_imm(instr);
			end
			B: begin
				unique case (instr.b_fmt.funct3)
					BEQ:     take = rs_eq;
					BNE:     take = !rs_eq;
					BLT:     take = rs_lt;
					BGE:     take = !rs_lt;
					default: take = 1'b0; // unsigned branches fall through
				endcase
			end
			default: take = 1'b0;
		endcase
		target = target_base + target_off;
		if (opcode == JALR) begin
			target[0] = 1'b0;
		end
		next_pc = take ? target : pc + data_t'(4);
	end

	assign pc_load  = state == S_EXEC;
	assign ls_start = (state == S_EXEC) && is_mem;
	assign ls_addr  = alu_c;
	assign ls_wdata = rs2_data;
	assign ls_we    = opcode == STORE;
	assign rd_data  = (state == S_MEM) ? ls_rdata : alu_c;
	assign rd_we    = (state == S_EXEC && alu_wr && opcode != LOAD) ||
		(state == S_MEM && ls_done && opcode == LOAD);

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= S_FETCH;
			fetch_wait  <= 1'b0;
			fetch_start <= 1'b0;
			halted      <= 1'b0;
		end else begin
			fetch_start <= 1'b0;
			unique case (state)
				S_FETCH: begin
					if (instr_valid) begin
						state      <= S_EXEC;
						fetch_wait <= 1'b0;
					end else if (!fetch_wait && !halted) begin
						fetch_start <= 1'b1;
						fetch_wait  <= 1'b1;
					end
				end
				S_EXEC: begin
					state <= is_mem ? S_MEM : S_FETCH;
					if (opcode == SYS) begin
						halted <= 1'b1; // no further fetches
					end
				end
				S_MEM: begin
					if (ls_done) begin
						state <= S_FETCH;
					end
				end
				default: state <= S_FETCH;
			endcase
		end
	end
endmodule

// File: logic/fetch_unit.sv
`include "rv_defs.svh"

module fetch_unit (
	input  logic             clk,
	input  logic             rst,
	input  logic             fetch_start,
	input  logic             pc_load,
	input  rv_pkg::data_t    next_pc,
	output rv_pkg::data_t    pc,
	output rv_pkg::instr_t   instr,
	output logic             instr_valid,
	output logic             req,
	output rv_pkg::mem_req_t req_bus,
	input  logic             ack,
	input  rv_pkg::data_t    rdata
);
	import rv_pkg::*;

	assign req_bus = '{addr: pc, wdata: NULL, we: 1'b0}; // pc holds still during a fetch

	always_ff @(posedge clk) begin
		if (rst) begin
			pc          <= `RESET_PC;
			req         <= 1'b0;
			instr_valid <= 1'b0;
		end else begin
			instr_valid <= 1'b0;
			if (pc_load) begin
				pc <= next_pc;
			end
			if (fetch_start) begin
				req <= 1'b1;
			end else if (ack) begin
				req         <= 1'b0; // drops the cycle after ack
				instr_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ack) begin
			instr <= instr_t'(rdata);
		end
	end
endmodule

// File: logic/lsu.sv
module lsu (
	input  logic             clk,
	input  logic             rst,
	input  logic             ls_start,
	input  rv_pkg::data_t    ls_addr,
	input  rv_pkg::data_t    ls_wdata,
	input  logic             ls_we,
	output rv_pkg::data_t    ls_rdata,
	output logic             ls_done,
	output logic             req,
	output rv_pkg::mem_req_t req_bus,
	input  logic             ack,
	input  rv_pkg::data_t    rdata
);
	always_ff @(posedge clk) begin
		if (rst) begin
			req     <= 1'b0;
			ls_done <= 1'b0;
		end else begin
			ls_done <= 1'b0;
			if (ls_start) begin
				req <= 1'b1;
			end else if (ack) begin
				req     <= 1'b0;
				ls_done <= 1'b1; // load data valid with this pulse
			end
		end
	end

	// access is frozen here so the bus stays stable while req is up
	always_ff @(posedge clk) begin
		if (ls_start) begin
			req_bus <= '{addr: ls_addr, wdata: ls_wdata, we: ls_we};
		end
		if (ack) begin
			ls_rdata <= rdata;
		end
	end
endmodule

// File: logic/mem_arbiter.sv
module mem_arbiter (
	input  logic             clk,
	input  logic             rst,
	input  logic             f_req,
	input  rv_pkg::mem_req_t f_bus,
	output logic             f_ack,
	input  logic             l_req,
	input  rv_pkg::mem_req_t l_bus,
	output logic             l_ack,
	output rv_pkg::data_t    rdata_out,
	output logic             mem_req,
	output rv_pkg::mem_req_t mem_bus,
	input  logic             mem_ack,
	input  rv_pkg::data_t    mem_rdata
);
	typedef enum logic [1:0] {OWN_IDLE, OWN_FETCH, OWN_LSU} owner_t;

	owner_t owner;

	always_ff @(posedge clk) begin
		if (rst) begin
			owner <= OWN_IDLE;
		end else if (owner == OWN_IDLE) begin
			if (l_req) begin
				owner <= OWN_LSU; // lsu wins a tie
			end else if (f_req) begin
				owner <= OWN_FETCH;
			end
		end else if (mem_ack) begin
			owner <= OWN_IDLE; // one idle cycle before the next grant
		end
	end

	assign mem_req   = owner != OWN_IDLE;
	assign mem_bus   = (owner == OWN_LSU) ? l_bus : f_bus;
	assign f_ack     = mem_ack && owner == OWN_FETCH;
	assign l_ack     = mem_ack && owner == OWN_LSU;
	assign rdata_out = mem_rdata; // only the acked owner samples it
endmodule

// File: logic/reg_file.sv
`include "rv_defs.svh"

module reg_file (
	input  logic          clk,
	input  logic          rst,
	input  logic [4:0]    rs1_addr,
	input  logic [4:0]    rs2_addr,
	output rv_pkg::data_t rs1_data,
	output rv_pkg::data_t rs2_data,
	input  logic [4:0]    rd_addr,
	input  rv_pkg::data_t rd_data,
	input  logic          rd_we
);
	import rv_pkg::*;

	data_t regs [`NUM_REGS];

	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= NULL;
			end
		end else if (rd_we && rd_addr != 5'd0) begin
			regs[rd_addr] <= rd_data; // x0 never written
		end
	end
endmodule

// File: logic/rv_core.sv
module rv_core (
	input  logic             clk,
	input  logic             rst,
	output logic             mem_req,
	output rv_pkg::mem_req_t mem_bus,
	input  logic             mem_ack,
	input  rv_pkg::data_t    mem_rdata,
	output logic             halted
);
	import rv_pkg::*;

	instr_t     instr;
	logic       instr_valid;
	logic       fetch_start;
	logic       pc_load;
	data_t      pc;
	data_t      next_pc;
	logic [4:0] rs1_addr;
	logic [4:0] rs2_addr;
	logic [4:0] rd_addr;
	data_t      rs1_data;
	data_t      rs2_data;
	data_t      rd_data;
	logic       rd_we;
	data_t      alu_a;
	data_t      alu_b;
	data_t      alu_c;
	logic       alu_wr;
	logic       ls_start;
	data_t      ls_addr;
	data_t      ls_wdata;
	logic       ls_we;
	data_t      ls_rdata;
	logic       ls_done;
	logic       f_req;
	logic       f_ack;
	mem_req_t   f_bus;
	logic       l_req;
	logic       l_ack;
	mem_req_t   l_bus;
	data_t      rdata; // shared read data from the arbiter

	core_ctrl u_ctrl (.*);

	reg_file u_regs (.*);

	alu u_alu (
		.instr (instr),
		.a_in  (alu_a),
		.b_in  (alu_b),
		.c_out (alu_c),
		.rd_wr (alu_wr)
	);

	fetch_unit u_fetch (
		.*,
		.req     (f_req),
		.req_bus (f_bus),
		.ack     (f_ack),
		.rdata   (rdata)
	);

	lsu u_lsu (
		.*,
		.req     (l_req),
		.req_bus (l_bus),
		.ack     (l_ack),
		.rdata   (rdata)
	);

	mem_arbiter u_arb (
		.*,
		.rdata_out (rdata)
	);
endmodule

// File: logic/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;
	typedef logic [`XLEN-1:0] data_t;

	localparam data_t NULL = '0;

	typedef enum logic [6:0] {
		R     = 7'b0110011,
		I     = 7'b0010011,
		LOAD  = 7'b0000011,
		STORE = 7'b0100011,
		B     = 7'b1100011,
		LUI   = 7'b0110111,
		AUIPC = 7'b0010111,
		JAL   = 7'b1101111,
		JALR  = 7'b1100111,
		MEM   = 7'b0001111, // fence, executed as a no-op
		SYS   = 7'b1110011
	} opcode_t;

	typedef enum logic [2:0] {
		ADD  = 3'b000, // sub when bit 30 is set
		SLL  = 3'b001,
		SLT  = 3'b010,
		SLTU = 3'b011,
		XOR  = 3'b100,
		SRL  = 3'b101, // sra when bit 30 is set
		OR   = 3'b110,
		AND  = 3'b111
	} funct3_t;

	// same field under its i-type and branch names
	localparam funct3_t ADDI  = ADD;
	localparam funct3_t SLLI  = SLL;
	localparam funct3_t SLTI  = SLT;
	localparam funct3_t SLTIU = SLTU;
	localparam funct3_t XORI  = XOR;
	localparam funct3_t SRLI  = SRL;
	localparam funct3_t ORI   = OR;
	localparam funct3_t ANDI  = AND;
	localparam funct3_t BEQ   = ADD;
	localparam funct3_t BNE   = SLL;
	localparam funct3_t BLT   = XOR;
	localparam funct3_t BGE   = SRL;

	typedef enum logic {logical, arithmetic} shift_type_t;

	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			funct3_t    funct3;
			logic [4:0] rd;
			opcode_t    opcode;
		} r_fmt;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			funct3_t     funct3;
			logic [4:0]  rd;
			opcode_t     opcode;
		} i_fmt;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			funct3_t    funct3;
			logic [4:0] imm_lo;
			opcode_t    opcode;
		} s_fmt;
		struct packed {
			logic       imm12;
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			funct3_t    funct3;
			logic [3:0] imm4_1;
			logic       imm11;
			opcode_t    opcode;
		} b_fmt;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			opcode_t     opcode;
		} u_fmt;
		struct packed {
			logic       imm20;
			logic [9:0] imm10_1;
			logic       imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			opcode_t    opcode;
		} j_fmt;
	} instr_t;

	typedef struct packed {
		data_t addr;
		data_t wdata;
		logic  we;
	} mem_req_t;

	function automatic data_t get_imm(instr_t ins);
		return {{(`XLEN-12){ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
	endfunction

	function automatic data_t get_imm_s(instr_t ins);
		return {{(`XLEN-12){ins.s_fmt.imm_hi[6]}}, ins.s_fmt.imm_hi, ins.s_fmt.imm_lo};
	endfunction

	function automatic data_t get_imm_b(instr_t ins);
		return {{(`XLEN-12){ins.b_fmt.imm12}}, ins.b_fmt.imm11, ins.b_fmt.imm10_5,
			ins.b_fmt.imm4_1, 1'b0};
	endfunction

	function automatic data_t get_imm_u(instr_t ins);
		return {ins.u_fmt.imm, 12'b0};
	endfunction

	function automatic data_t get_imm_j(instr_t ins);
		return {{(`XLEN-20){ins.j_fmt.imm20}}, ins.j_fmt.imm19_12, ins.j_fmt.imm11,
			ins.j_fmt.imm10_1, 1'b0};
	endfunction
endpackage

// File: sources.f
+incdir+include
logic/rv_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/fetch_unit.sv
logic/lsu.sv
logic/mem_arbiter.sv
logic/core_ctrl.sv
logic/rv_core.sv
test/tb_rv_core.sv

// File: test/tb_rv_core.sv
`include "rv_defs.svh"

module tb_rv_core;
	import rv_pkg::*;

	localparam int MEM_WORDS = 2048;
	localparam data_t MEM_BYTES = 32'(MEM_WORDS * 4);
	localparam data_t DATA_BASE = 32'h0000_1000; // x31 points here
	localparam int FIRST_REQ_TIMEOUT = 20;
	localparam int HALT_TIMEOUT = 20000;

	localparam logic [6:0] OPC_R     = 7'h33;
	localparam logic [6:0] OPC_I     = 7'h13;
	localparam logic [6:0] OPC_LOAD  = 7'h03;
	localparam logic [6:0] OPC_STORE = 7'h23;
	localparam logic [6:0] OPC_BR    = 7'h63;
	localparam logic [6:0] OPC_LUI   = 7'h37;
	localparam logic [6:0] OPC_AUIPC = 7'h17;
	localparam logic [6:0] OPC_JAL   = 7'h6f;
	localparam logic [6:0] OPC_JALR  = 7'h67;
	localparam logic [6:0] OPC_SYS   = 7'h73;

	// one nibble per op, {alt bit, funct3}, op 0 in the low nibble
	localparam logic [39:0] R_OPS = 40'hD513_2467_80;
	localparam logic [35:0] I_OPS = 36'hD51_3246_70;

	logic     clk;
	logic     rst;
	logic     mem_req;
	mem_req_t mem_bus;
	logic     mem_ack;
	data_t    mem_rdata;
	logic     halted;

	data_t       mem [MEM_WORDS];
	data_t       log_addr[$];
	data_t       log_data[$];
	data_t       exp_addr[$];
	data_t       exp_data[$];
	int          exp_test[$];
	data_t       prog_pc;
	data_t       sys_addr;
	data_t       last_read;
	int          store_off;
	int          wait_left;
	int          cycles;
	logic [15:0] lfsr;
	int          checks [1:6];
	int          errors [1:6];

	rv_core u_dut (
		.clk       (clk),
		.rst       (rst),
		.mem_req   (mem_req),
		.mem_bus   (mem_bus),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata),
		.halted    (halted)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// fibonacci lfsr, taps 16 14 13 11, one step per bit
	function automatic data_t rand_bits(int n);
		data_t v;
		logic  fb;
		v = NULL;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	// expected result by the rv32i rules, b is rs2 or the extended immediate
	function automatic data_t ref_result(logic [6:0] opc, logic [2:0] f3, logic alt,
		data_t a, data_t b);
		data_t r;
		case (f3)
			3'd0: r = (opc == OPC_R && alt) ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: r = (a < b) ? 32'd1 : 32'd0;
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt) begin
					r = $signed(a) >>> b[4:0];
				end else begin
					r = a >> b[4:0];
				end
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	function automatic logic branch_taken(logic [2:0] f3, data_t a, data_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			default: return !($signed(a) < $signed(b)); // bge
		endcase
	endfunction

	function automatic data_t enc_r(logic alt, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_R};
	endfunction

	function automatic data_t enc_i(logic [6:0] opc, logic [11:0] imm, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic data_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
	endfunction

	function automatic data_t enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BR};
	endfunction

	function automatic data_t enc_u(logic [6:0] opc, logic [19:0] imm, logic [4:0] rd);
		return {imm, rd, opc};
	endfunction

	function automatic data_t enc_j(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	task automatic emit(data_t word);
		mem[prog_pc[12:2]] = word;
		prog_pc += 4;
	endtask

	task automatic load_const(logic [4:0] rd, data_t v);
		data_t upper;
		upper = v + 32'h800; // addi sign-extends the low part
		emit(enc_u(OPC_LUI, upper[31:12], rd));
		emit(enc_i(OPC_I, v[11:0], rd, 3'b000, rd));
	endtask

	task automatic store_word(logic [4:0] rs, data_t v, int t, logic logged);
		emit(enc_s(12'(store_off), rs, 5'd31));
		if (logged) begin
			exp_addr.push_back(DATA_BASE + data_t'(store_off));
			exp_data.push_back(v);
			exp_test.push_back(t);
		end
		store_off += 4;
	endtask

	task automatic build_program();
		data_t      a;
		data_t      b;
		data_t      v;
		data_t      at;
		data_t      marker;
		logic [3:0] op;
		logic [11:0] imm;
		logic [4:0] shamt;
		logic [2:0] br_f3;
		lfsr      = 16'd33032;
		prog_pc   = `RESET_PC;
		store_off = 0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = {25'(i * 4), OPC_SYS}; // runaway code halts
		end
		load_const(5'd31, DATA_BASE);
		for (int p = 0; p < 4; p++) begin
			a = rand_bits(32);
			b = rand_bits(32);
			load_const(5'd1, a);
			load_const(5'd2, b);
			for (int k = 0; k < 10; k++) begin
				op = R_OPS[4*k +: 4];
				emit(enc_r(op[3], 5'd2, 5'd1, op[2:0], 5'd3));
				store_word(5'd3, ref_result(OPC_R, op[2:0], op[3], a, b), 2, 1'b1);
			end
		end
		for (int p = 0; p < 4; p++) begin
			a = rand_bits(32);
			load_const(5'd1, a);
			for (int k = 0; k < 9; k++) begin
				op = I_OPS[4*k +: 4];
				if (op[2:0] == 3'd1 || op[2:0] == 3'd5) begin
					shamt = 5'(rand_bits(5));
					imm   = {1'b0, op[3], 5'b0, shamt}; // bit 30 selects srai
					b     = 32'(shamt);
				end else begin
					imm = 12'(rand_bits(12));
					b   = {{20{imm[11]}}, imm};
				end
				emit(enc_i(OPC_I, imm, 5'd1, op[2:0], 5'd3));
				store_word(5'd3, ref_result(OPC_I, op[2:0], op[3], a, b), 3, 1'b1);
			end
		end
		v = rand_bits(20);
		emit(enc_u(OPC_LUI, v[19:0], 5'd3));
		store_word(5'd3, {v[19:0], 12'b0}, 4, 1'b1);
		v  = rand_bits(20);
		at = prog_pc;
		emit(enc_u(OPC_AUIPC, v[19:0], 5'd3));
		store_word(5'd3, at + {v[19:0], 12'b0}, 4, 1'b1);
		at = prog_pc;
		emit(enc_j(21'd8, 5'd3));
		emit(data_t'(OPC_SYS)); // skipped when the jump lands
		store_word(5'd3, at + 4, 4, 1'b1);
		at = prog_pc + 8; // jalr sits after the two-word constant
		load_const(5'd5, at + 8 - 7); // odd sum, bit 0 cleared by jalr
		emit(enc_i(OPC_JALR, 12'd8, 5'd5, 3'b000, 5'd3));
		emit(data_t'(OPC_SYS));
		store_word(5'd3, at + 4, 4, 1'b1);
		marker = rand_bits(32);
		load_const(5'd6, marker);
		v = rand_bits(32);
		for (int p = 0; p < 3; p++) begin
			a = (p == 2) ? v ^ 32'h8000_0000 : v;
			b = (p == 1) ? v ^ 32'h8000_0000 : v;
			load_const(5'd1, a);
			load_const(5'd2, b);
			for (int k = 0; k < 4; k++) begin
				br_f3 = (k < 2) ? 3'(k) : 3'(k + 2); // beq bne blt bge
				emit(enc_b(13'd8, 5'd2, 5'd1, br_f3));
				store_word(5'd6, marker, 5, !branch_taken(br_f3, a, b));
			end
		end
		for (int p = 0; p < 2; p++) begin
			v = rand_bits(32);
			load_const(5'd7, v);
			store_word(5'd7, v, 6, 1'b1);
			emit(enc_i(OPC_LOAD, 12'(store_off - 4), 5'd31, 3'b010, 5'd8));
			store_word(5'd8, v, 6, 1'b1);
		end
		sys_addr = prog_pc;
		emit(data_t'(OPC_SYS));
	endtask

	task automatic check_value(int t, string name, data_t got, data_t exp);
		checks[t]++;
		assert (got == exp) else begin
			$display("FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
			errors[t]++;
		end
	endtask

	task automatic check_true(int t, logic cond, string what);
		checks[t]++;
		assert (cond) else begin
			$display("%s", what);
			errors[t]++;
		end
	endtask

	// memory model, acks after 1 to 3 cycles and logs every write
	task automatic serve_request();
		check_true(1, mem_bus.addr < MEM_BYTES && mem_bus.addr[1:0] == 2'b00,
			$sformatf("bus access outside the memory at 0x%08h", mem_bus.addr));
		if (mem_bus.we) begin
			mem[mem_bus.addr[12:2]] = mem_bus.wdata;
			log_addr.push_back(mem_bus.addr);
			log_data.push_back(mem_bus.wdata);
		end else begin
			mem_rdata = mem[mem_bus.addr[12:2]];
			last_read = mem_bus.addr;
		end
		mem_ack = 1'b1;
	endtask

	initial begin
		mem_ack   = 1'b0;
		mem_rdata = NULL;
		wait_left = 0;
		forever begin
			@(posedge clk);
			#1;
			if (mem_ack || rst) begin
				mem_ack = 1'b0;
			end else if (mem_req) begin
				if (wait_left == 0) begin
					wait_left = int'(rand_bits(2) % 3) + 1;
				end
				wait_left--;
				if (wait_left == 0) begin
					serve_request();
				end
			end
		end
	end

	function automatic string test_name(int t);
		case (t)
			1: return "reset and halt";
			2: return "register ops";
			3: return "immediate ops";
			4: return "upper and jumps";
			5: return "branches";
			default: return "store and load path";
		endcase
	endfunction

	task automatic print_test_line(int t);
		$display("test %0d %s: %0d checks, %0d errors", t, test_name(t), checks[t], errors[t]);
	endtask

	task automatic compare_writes();
		int t;
		for (int i = 0; i < exp_addr.size(); i++) begin
			t = exp_test[i];
			check_true(t, i < log_addr.size(),
				$sformatf("write %0d to 0x%08h never reached the bus", i, exp_addr[i]));
			if (i < log_addr.size()) begin
				check_value(t, "mem_bus.addr", log_addr[i], exp_addr[i]);
				check_value(t, "mem_bus.wdata", log_data[i], exp_data[i]);
			end
			if (i == exp_addr.size() - 1 || exp_test[i + 1] != t) begin
				print_test_line(t);
			end
		end
	endtask

	task automatic finish_run();
		int total;
		int failed;
		total  = 0;
		failed = 0;
		for (int t = 1; t <= 6; t++) begin
			total  += checks[t];
			failed += errors[t];
		end
		$display("checks: %0d passed, %0d failed", total - failed, failed);
		if (failed == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	endtask

	initial begin
		rst = 1'b1;
		for (int t = 1; t <= 6; t++) begin
			checks[t] = 0;
			errors[t] = 0;
		end
		build_program();
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		check_true(1, !halted, "halted is high right after reset");
		cycles = 0;
		while (!mem_req && cycles < FIRST_REQ_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		check_true(1, mem_req, "no bus request after reset");
		check_value(1, "mem_bus.addr", mem_bus.addr, `RESET_PC);
		check_value(1, "mem_bus.we", data_t'(mem_bus.we), NULL);
		cycles = 0;
		while (!halted && cycles < HALT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			$display("timeout: core did not halt within %0d cycles", HALT_TIMEOUT);
			$display("TESTS FAILED");
			$finish;
		end else begin
			check_value(1, "mem_bus.addr", last_read, sys_addr); // last fetch is the sys
			check_true(1, log_addr.size() == exp_addr.size(),
				$sformatf("core wrote %0d words before halting, %0d expected",
				log_addr.size(), exp_addr.size()));
			print_test_line(1);
			compare_writes();
			finish_run();
		end
	end
endmodule
